// ==== verilog/ins_decoder_pkg.sv ====
// decoder codes: status, operand source, alu op and form enums, class and micro-step structs
package ins_decoder_pkg;

    typedef logic [3:0] phase_t;  // run phase and phase count

    typedef enum logic [2:0] {
        st_nop       = 3'd0,
        st_ram_read  = 3'd1,
        st_rom_read  = 3'd2,
        st_process   = 3'd3,
        st_ram_write = 3'd4,
        st_get_ins   = 3'd5,
        st_not_done  = 3'd7
    } status_e;

    typedef enum logic [3:0] {
        src_a        = 4'd0,
        src_ram_data = 4'd1,
        src_rom_data = 4'd2,
        src_none     = 4'd7
    } data_src_e;

    typedef enum logic [3:0] {
        alu_none = 4'd0,
        alu_add  = 4'd1,
        alu_addc = 4'd2,
        alu_subb = 4'd3,
        alu_anl  = 4'd4,
        alu_orl  = 4'd5,
        alu_xrl  = 4'd6,
        alu_mov  = 4'd7,
        alu_inc  = 4'd8,
        alu_dec  = 4'd9,
        alu_clr  = 4'd10,
        alu_cpl  = 4'd11
    } alu_op_e;

    typedef enum logic [4:0] {
        f_nop,
        f_illegal,
        f_mov_rn_a,
        f_mov_ri_a,
        f_mov_dir_a,
        f_mov_rn_imm,
        f_mov_dir_imm,
        f_mov_dir_rn,
        f_mov_rn_dir,
        f_mov_dir_dir,
        f_unary_a,     // inc/dec/clr/cpl a
        f_unary_rn,
        f_unary_dir,
        f_alu_rn,      // a op= rn
        f_alu_ri,
        f_alu_imm,
        f_alu_dir
    } ins_form_e;

    typedef struct packed {
        ins_form_e   form;
        alu_op_e     op;        // only for unary/alu forms
        logic [7:0]  reg_addr;  // ram address of rn or ri in current bank
    } ins_class_t;

    typedef struct packed {
        status_e     status;
        data_src_e   a_src;
        data_src_e   b_src;
        alu_op_e     op;
        logic [7:0]  addr;
        logic        addr_from_tmp;  // use the temp address register
        logic        capture_tmp;    // load rom data into temp at next edge
    } micro_step_t;

    localparam micro_step_t step_idle = '{
        status:        st_nop,
        a_src:         src_none,
        b_src:         src_none,
        op:            alu_none,
        addr:          8'h00,
        addr_from_tmp: 1'b0,
        capture_tmp:   1'b0
    };

endpackage

// ==== verilog/opcode_classifier.sv ====
// opcode classifier: opcode and psw bank to instruction form, alu op and register address
`timescale 1ns/1ps

module opcode_classifier (
    input  logic [7:0]                 instruction,
    input  logic [7:0]                 psw,
    output ins_decoder_pkg::ins_class_t ins_class
);
    import ins_decoder_pkg::*;

    logic [1:0] bank;
    logic [7:0] rn_addr;
    logic [7:0] ri_addr;
    logic       alu_group;
    ins_form_e  form;

    assign bank    = psw[4:3];  // rs1:rs0
    assign rn_addr = {3'b000, bank, instruction[2:0]};
    assign ri_addr = {3'b000, bank, 2'b00, instruction[0]};

    // high nibbles of the accumulator alu group
    assign alu_group = instruction[7:4] inside {4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'h9, 4'hE};

    function automatic alu_op_e nibble_op(input logic [7:0] opc);
        alu_op_e op;
        case (opc[7:4])
            4'h0:       op = alu_inc;
            4'h1:       op = alu_dec;
            4'h2:       op = alu_add;
            4'h3:       op = alu_addc;
            4'h4:       op = alu_orl;
            4'h5:       op = alu_anl;
            4'h6:       op = alu_xrl;
            4'h9:       op = alu_subb;
            4'h7, 4'hE: op = alu_mov;  // 74 is mov a,#data
            default:    op = alu_none;
        endcase
        if (opc == 8'hE4) begin
            op = alu_clr;
        end else if (opc == 8'hF4) begin
            op = alu_cpl;
        end
        return op;
    endfunction

    always_comb begin
        form = f_illegal;
        casez (instruction)
            8'h00:       form = f_nop;
            8'b1111_1???: form = f_mov_rn_a;
            8'b1111_011?: form = f_mov_ri_a;
            8'hF5:       form = f_mov_dir_a;
            8'b0111_1???: form = f_mov_rn_imm;
            8'h75:       form = f_mov_dir_imm;
            8'b1000_1???: form = f_mov_dir_rn;
            8'b1010_1???: form = f_mov_rn_dir;
            8'h85:       form = f_mov_dir_dir;
            8'b000?_0100,
            8'hE4,
            8'hF4:       form = f_unary_a;
            8'b000?_1???: form = f_unary_rn;
            8'b000?_0101: form = f_unary_dir;
            8'h74:       form = f_alu_imm;
            default: begin
                if (alu_group) begin
                    casez (instruction[3:0])
                        4'b1???: form = f_alu_rn;
                        4'b011?: form = f_alu_ri;
                        4'b0100: form = f_alu_imm;
                        4'b0101: form = f_alu_dir;
                        default: form = f_illegal;
                    endcase
                end
            end
        endcase

        ins_class.form = form;
        if (form inside {f_unary_a, f_unary_rn, f_unary_dir,
                         f_alu_rn, f_alu_ri, f_alu_imm, f_alu_dir}) begin
            ins_class.op = nibble_op(instruction);
        end else begin
            ins_class.op = alu_none;
        end
        // bit 3 set means rn, else the ri encoding
        ins_class.reg_addr = instruction[3] ? rn_addr : ri_addr;
    end

endmodule

// ==== verilog/phase_sequencer.sv ====
// phase sequencer: phase table per instruction form, one micro-step per run phase
`timescale 1ns/1ps

module phase_sequencer (
    input  ins_decoder_pkg::ins_class_t  ins_class,
    input  ins_decoder_pkg::phase_t      run_phase,
    input  logic [7:0]                   ram_data_register,
    input  logic [7:0]                   rom_data_register,
    output ins_decoder_pkg::phase_t      run_phase_init,
    output ins_decoder_pkg::micro_step_t step
);
    import ins_decoder_pkg::*;

    function automatic micro_step_t ram_read(input logic [7:0] addr);
        micro_step_t s;
        s        = step_idle;
        s.status = st_ram_read;
        s.addr   = addr;
        return s;
    endfunction

    function automatic micro_step_t rom_read(input logic capture);
        micro_step_t s;
        s             = step_idle;
        s.status      = st_rom_read;
        s.capture_tmp = capture;
        return s;
    endfunction

    function automatic micro_step_t ram_write(input data_src_e src, input logic [7:0] addr,
                                              input logic from_tmp);
        micro_step_t s;
        s               = step_idle;
        s.status        = st_ram_write;
        s.a_src         = src;  // a source only
        s.addr          = addr;
        s.addr_from_tmp = from_tmp;
        return s;
    endfunction

    function automatic micro_step_t process(input data_src_e a, input data_src_e b,
                                            input alu_op_e op);
        micro_step_t s;
        s        = step_idle;
        s.status = st_process;
        s.a_src  = a;
        s.b_src  = b;
        s.op     = op;
        return s;
    endfunction

    logic [7:0] rn;
    logic [7:0] dir;
    alu_op_e    op;

    assign rn  = ins_class.reg_addr;
    assign dir = rom_data_register;  // direct address fetched from rom
    assign op  = ins_class.op;

    always_comb begin
        run_phase_init = 4'd0;
        step           = step_idle;
        step.status    = st_not_done;  // phase outside 1..N

        case (ins_class.form)
            f_nop: begin
                step.status = st_nop;
            end
            f_mov_rn_a: begin
                run_phase_init = 4'd1;
                if (run_phase == 4'd1) step = ram_write(src_a, rn, 1'b0);
            end
            f_mov_ri_a: begin
                run_phase_init = 4'd2;
                case (run_phase)
                    4'd2: step = ram_read(rn);
                    4'd1: step = ram_write(src_a, ram_data_register, 1'b0);
                    default: ;
                endcase
            end
            f_mov_dir_a: begin
                run_phase_init = 4'd2;
                case (run_phase)
                    4'd2: step = rom_read(1'b0);
                    4'd1: step = ram_write(src_a, dir, 1'b0);
                    default: ;
                endcase
            end
            f_mov_rn_imm: begin
                run_phase_init = 4'd2;
                case (run_phase)
                    4'd2: step = rom_read(1'b0);
                    4'd1: step = ram_write(src_rom_data, rn, 1'b0);
                    default: ;
                endcase
            end
            f_mov_dir_imm: begin
                run_phase_init = 4'd3;
                case (run_phase)
                    4'd3: step = rom_read(1'b0);
                    4'd2: step = rom_read(1'b1);  // dest address into temp
                    4'd1: step = ram_write(src_rom_data, 8'h00, 1'b1);
                    default: ;
                endcase
            end
            f_mov_dir_rn: begin
                run_phase_init = 4'd3;
                case (run_phase)
                    4'd3: step = rom_read(1'b0);
                    4'd2: step = ram_read(rn);
                    4'd1: step = ram_write(src_ram_data, dir, 1'b0);
                    default: ;
                endcase
            end
            f_mov_rn_dir: begin
                run_phase_init = 4'd3;
                case (run_phase)
                    4'd3: step = rom_read(1'b0);
                    4'd2: step = ram_read(dir);
                    4'd1: step = ram_write(src_ram_data, rn, 1'b0);
                    default: ;
                endcase
            end
            f_mov_dir_dir: begin
                run_phase_init = 4'd4;
                case (run_phase)
                    4'd4: step = rom_read(1'b0);
                    4'd3: step = rom_read(1'b1);
                    4'd2: step = ram_read(dir);
                    4'd1: step = ram_write(src_ram_data, 8'h00, 1'b1);
                    default: ;
                endcase
            end
            f_unary_a: begin
                run_phase_init = 4'd1;
                if (run_phase == 4'd1) step = process(src_a, src_none, op);
            end
            f_unary_rn: begin
                run_phase_init = 4'd3;
                case (run_phase)
                    4'd3: step = ram_read(rn);
                    4'd2: step = process(src_ram_data, src_none, op);
                    4'd1: step = ram_write(src_ram_data, rn, 1'b0);
                    default: ;
                endcase
            end
            f_unary_dir: begin
                run_phase_init = 4'd4;
                case (run_phase)
                    4'd4: step = rom_read(1'b0);
                    4'd3: step = ram_read(dir);
                    4'd2: step = process(src_ram_data, src_none, op);
                    4'd1: step = ram_write(src_ram_data, dir, 1'b0);
                    default: ;
                endcase
            end
            f_alu_rn: begin
                run_phase_init = 4'd2;
                case (run_phase)
                    4'd2: step = ram_read(rn);
                    4'd1: step = process(src_a, src_ram_data, op);
                    default: ;
                endcase
            end
            f_alu_ri: begin
                run_phase_init = 4'd3;
                case (run_phase)
                    4'd3: step = ram_read(rn);
                    4'd2: step = ram_read(ram_data_register);  // follow the pointer
                    4'd1: step = process(src_a, src_ram_data, op);
                    default: ;
                endcase
            end
            f_alu_imm: begin
                run_phase_init = 4'd2;
                case (run_phase)
                    4'd2: step = rom_read(1'b0);
                    4'd1: step = process(src_a, src_rom_data, op);
                    default: ;
                endcase
            end
            f_alu_dir: begin
                run_phase_init = 4'd3;
                case (run_phase)
                    4'd3: step = rom_read(1'b0);
                    4'd2: step = ram_read(dir);
                    4'd1: step = process(src_a, src_ram_data, op);
                    default: ;
                endcase
            end
            default: begin
                step.status = st_get_ins;  // illegal opcode, skip it
            end
        endcase
    end

endmodule

// ==== verilog/step_encoder.sv ====
// step encoder: temporary address register and control outputs from the micro-step
`timescale 1ns/1ps

module step_encoder (
    input  logic                         clk,
    input  logic                         rst_n,
    input  ins_decoder_pkg::micro_step_t step,
    input  logic [7:0]                   rom_data_register,
    output ins_decoder_pkg::status_e     next_status,
    output ins_decoder_pkg::data_src_e   a_data_from,
    output ins_decoder_pkg::data_src_e   b_data_from,
    output ins_decoder_pkg::alu_op_e     alu_op,
    output logic [7:0]                   addr_register_out
);

    logic [7:0] tmp_addr;

    // holds the destination byte of the direct-target moves
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tmp_addr <= 8'h00;
        end else if (step.capture_tmp) begin
            tmp_addr <= rom_data_register;  // repeats while phase is held
        end
    end

    always_comb begin
        next_status = step.status;
        a_data_from = step.a_src;
        b_data_from = step.b_src;
        alu_op      = step.op;
        if (step.addr_from_tmp) begin
            addr_register_out = tmp_addr;
        end else begin
            addr_register_out = step.addr;
        end
    end

endmodule

// ==== verilog/ins_decoder_top.sv ====
// instruction decoder top: classifier, phase sequencer and step encoder
`timescale 1ns/1ps

module ins_decoder_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [7:0]                 instruction,
    input  ins_decoder_pkg::phase_t    run_phase,
    input  logic [7:0]                 psw,
    input  logic [7:0]                 ram_data_register,
    input  logic [7:0]                 rom_data_register,
    output ins_decoder_pkg::phase_t    run_phase_init,
    output ins_decoder_pkg::status_e   next_status,
    output ins_decoder_pkg::data_src_e a_data_from,
    output ins_decoder_pkg::data_src_e b_data_from,
    output ins_decoder_pkg::alu_op_e   alu_op,
    output logic [7:0]                 addr_register_out
);
    import ins_decoder_pkg::*;

    ins_class_t  ins_class;
    micro_step_t step;

    opcode_classifier i_classifier (
        .instruction (instruction),
        .psw         (psw),
        .ins_class   (ins_class)
    );

    phase_sequencer i_sequencer (
        .ins_class         (ins_class),
        .run_phase         (run_phase),
        .ram_data_register (ram_data_register),
        .rom_data_register (rom_data_register),
        .run_phase_init    (run_phase_init),
        .step              (step)
    );

    step_encoder i_encoder (
        .clk               (clk),
        .rst_n             (rst_n),
        .step              (step),
        .rom_data_register (rom_data_register),
        .next_status       (next_status),
        .a_data_from       (a_data_from),
        .b_data_from       (b_data_from),
        .alu_op            (alu_op),
        .addr_register_out (addr_register_out)
    );

endmodule

// ==== include/ins_decoder_tb_tasks.svh ====
// edge and settle waits, field compare, phase walk and the directed decoder tests

task automatic next_fall();
    int edges;
    edges = 0;
    do begin
        @(clk);
        edges++;
    end while (clk !== 1'b0 && edges < 3);
    assert (clk === 1'b0) else begin
        timeouts++;
        $display("timeout at %0t ns: no falling clock edge seen", $time);
    end
endtask

// outputs are combinational, give them a few ns to become known
task automatic settle();
    int guard;
    guard = 0;
    do begin
        #1;
        guard++;
    end while ($isunknown(dut_outs) && guard < 4);
    assert (!$isunknown(dut_outs)) else begin
        timeouts++;
        $display("timeout at %0t ns: decoder outputs still unknown", $time);
    end
endtask

task automatic check_field(input string name, input logic [7:0] got, input logic [7:0] want);
    checks++;
    assert (got === want) else begin
        errors++;
        $display("mismatch at %0t ns: %s expected %0h, got %0h", $time, name, want, got);
    end
endtask

// drive one phase at the falling edge and compare every output
task automatic apply(input logic [7:0] opc, input logic [7:0] psw_v, input int ph);
    exp_step_t  e;
    logic [7:0] rom_b;
    next_fall();
    rom_b = lcg_byte();
    if (rom_b == rom_data_register) rom_b = ~rom_b;  // rom byte changes every phase
    instruction       = opc;
    psw               = psw_v;
    run_phase         = phase_t'(ph);
    ram_data_register = lcg_byte();
    rom_data_register = rom_b;
    settle();
    e = expect_step(opc, psw_v, ph, ram_data_register, rom_data_register, model_tmp);
    check_field("run_phase_init", 8'(run_phase_init), 8'(need_phases(opc)));
    check_field("next_status", 8'(next_status), 8'(e.status));
    check_field("a_data_from", 8'(a_data_from), 8'(e.a_src));
    check_field("b_data_from", 8'(b_data_from), 8'(e.b_src));
    check_field("alu_op", 8'(alu_op), 8'(e.op));
    check_field("addr_register_out", addr_register_out, e.addr);
    if (e.cap) model_tmp = rom_data_register;  // loads at the coming rising edge
endtask

task automatic walk(input logic [7:0] opc, input logic [7:0] psw_v);
    int p;
    apply(opc, psw_v, 0);
    for (p = need_phases(opc); p >= 1; p--) begin
        apply(opc, psw_v, p);
    end
endtask

task automatic test_reset_state();
    apply(8'h75, lcg_byte(), 1);  // temp register still 0
    walk(8'h00, lcg_byte());
    walk(8'hA5, lcg_byte());
    apply(8'hA5, lcg_byte(), 5);
    walk(with_reg(8'hF8), lcg_byte());
endtask

task automatic test_moves();
    logic [7:0] forms [8];
    forms = '{8'hF8, 8'hF6, 8'hF5, 8'h78, 8'h75, 8'h88, 8'hA8, 8'h85};
    foreach (forms[i]) begin
        repeat (3) walk(with_reg(forms[i]), lcg_byte());
    end
endtask

task automatic test_alu();
    logic [3:0] ops [7];
    logic [3:0] modes [4];
    ops   = '{4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'h9, 4'hE};
    modes = '{4'h8, 4'h6, 4'h4, 4'h5};  // rn, @ri, #data, direct
    foreach (ops[i]) begin
        foreach (modes[j]) begin
            walk(with_reg({ops[i], modes[j]}), lcg_byte());
        end
    end
    walk(8'h74, lcg_byte());
endtask

task automatic test_unary();
    logic [7:0] opcs [8];
    opcs = '{8'h04, 8'h14, 8'hE4, 8'hF4, 8'h08, 8'h18, 8'h05, 8'h15};
    foreach (opcs[i]) begin
        walk(with_reg(opcs[i]), lcg_byte());
    end
endtask

task automatic test_direct_target();
    repeat (4) begin
        walk(8'h75, lcg_byte());
        walk(8'h85, lcg_byte());
    end
endtask

task automatic test_banks();
    int b;
    for (b = 0; b < 4; b++) begin
        walk(with_reg(8'h28), 8'(b) << 3);
        walk(with_reg(8'h28), (lcg_byte() & 8'hE7) | (8'(b) << 3));
        walk(with_reg(8'h26), (lcg_byte() & 8'hE7) | (8'(b) << 3));
    end
endtask

// ==== testbench/tb_ins_decoder.sv ====
// testbench for the instruction decoder: clock, reset, lcg, reference model and test sequence
`timescale 1ns/1ps

module tb_ins_decoder;
    import ins_decoder_pkg::*;

    typedef struct packed {
        status_e    status;
        data_src_e  a_src;
        data_src_e  b_src;
        alu_op_e    op;
        logic [7:0] addr;
        logic       cap;    // step loads the temp register
    } exp_step_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic [7:0]  instruction;
    phase_t      run_phase;
    logic [7:0]  psw;
    logic [7:0]  ram_data_register;
    logic [7:0]  rom_data_register;
    phase_t      run_phase_init;
    status_e     next_status;
    data_src_e   a_data_from;
    data_src_e   b_data_from;
    alu_op_e     alu_op;
    logic [7:0]  addr_register_out;
    logic [26:0] dut_outs;

    int unsigned lcg_state;
    int          checks;
    int          errors;
    int          timeouts;
    logic [7:0]  model_tmp;  // expected temp address register

    assign dut_outs = {run_phase_init, next_status, a_data_from, b_data_from, alu_op,
                       addr_register_out};

    ins_decoder_top i_dut (
        .clk               (clk),
        .rst_n             (rst_n),
        .instruction       (instruction),
        .run_phase         (run_phase),
        .psw               (psw),
        .ram_data_register (ram_data_register),
        .rom_data_register (rom_data_register),
        .run_phase_init    (run_phase_init),
        .next_status       (next_status),
        .a_data_from       (a_data_from),
        .b_data_from       (b_data_from),
        .alu_op            (alu_op),
        .addr_register_out (addr_register_out)
    );

    always #5 clk = ~clk;

    function automatic logic [7:0] lcg_byte();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:16];
    endfunction

    // fills a random rn or ri index into a base opcode
    function automatic logic [7:0] with_reg(input logic [7:0] base);
        logic [7:0] mask;
        mask = base[3] ? 8'h07 : ((base[2:1] == 2'b11) ? 8'h01 : 8'h00);
        return base | (lcg_byte() & mask);
    endfunction

    // steps from phase N down to 1, three chars each: kind, first operand, second operand
    function automatic string recipe(input logic [7:0] opc);
        casez (opc)
            8'h00:         return "";
            8'hF5:         return "o--wad";
            8'b1111_011?:  return "r-nwam";
            8'b1111_1???:  return "wan";
            8'h75:         return "o--oc-wrt";
            8'b0111_1???:  return "o--wrn";
            8'b1000_1???:  return "o--r-nwmd";
            8'b1010_1???:  return "o--r-dwmn";
            8'h85:         return "o--oc-r-dwmt";
            8'h04, 8'h14,
            8'hE4, 8'hF4:  return "pa-";
            8'b000?_1???:  return "r-npm-wmn";
            8'h05, 8'h15:  return "o--r-dpm-wmd";
            8'h74:         return "o--par";
            default: ;
        endcase
        if (opc[7:4] inside {4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'h9, 4'hE}) begin
            if (opc[3]) return "r-npam";
            if (opc[3:1] == 3'b011) return "r-nr-mpam";
            if (opc[3:0] == 4'h4) return "o--par";
            if (opc[3:0] == 4'h5) return "o--r-dpam";
        end
        return "!";  // illegal
    endfunction

    function automatic int need_phases(input logic [7:0] opc);
        string r;
        r = recipe(opc);
        return r.len() / 3;
    endfunction

    function automatic alu_op_e op_of(input logic [7:0] opc);
        if (opc == 8'hE4) return alu_clr;
        if (opc == 8'hF4) return alu_cpl;
        case (opc[7:4])
            4'h0:       return alu_inc;
            4'h1:       return alu_dec;
            4'h2:       return alu_add;
            4'h3:       return alu_addc;
            4'h4:       return alu_orl;
            4'h5:       return alu_anl;
            4'h6:       return alu_xrl;
            4'h9:       return alu_subb;
            4'h7, 4'hE: return alu_mov;
            default:    return alu_none;
        endcase
    endfunction

    function automatic data_src_e src_of(input byte c);
        case (c)
            "a":     return src_a;
            "m":     return src_ram_data;
            "r":     return src_rom_data;
            default: return src_none;
        endcase
    endfunction

    function automatic exp_step_t expect_step(input logic [7:0] opc, input logic [7:0] psw_v,
                                              input int ph, input logic [7:0] ram,
                                              input logic [7:0] rom, input logic [7:0] tmp);
        string      r;
        int         n;
        int         k;
        logic [7:0] reg_a;
        logic [7:0] where;
        exp_step_t  e;
        r     = recipe(opc);
        n     = r.len() / 3;
        reg_a = 8'(psw_v[4:3]) * 8'd8 + (opc[3] ? 8'(opc[2:0]) : 8'(opc[0]));
        e     = '{st_not_done, src_none, src_none, alu_none, 8'h00, 1'b0};
        if (r == "") begin
            e.status = st_nop;
        end else if (r == "!") begin
            e.status = st_get_ins;
        end else if (ph >= 1 && ph <= n) begin
            k = (n - ph) * 3;
            case (r[k+2])
                "n":     where = reg_a;
                "d":     where = rom;  // direct address from rom
                "m":     where = ram;
                "t":     where = tmp;
                default: where = 8'h00;
            endcase
            case (r[k])
                "o": begin
                    e.status = st_rom_read;
                    e.cap    = (r[k+1] == "c");
                end
                "r": begin
                    e.status = st_ram_read;
                    e.addr   = where;
                end
                "p": begin
                    e.status = st_process;
                    e.a_src  = src_of(r[k+1]);
                    e.b_src  = src_of(r[k+2]);
                    e.op     = op_of(opc);
                end
                default: begin
                    e.status = st_ram_write;
                    e.a_src  = src_of(r[k+1]);
                    e.addr   = where;
                end
            endcase
        end
        return e;
    endfunction

    `include "ins_decoder_tb_tasks.svh"

    initial begin
        lcg_state         = 32'hf900;
        checks            = 0;
        errors            = 0;
        timeouts          = 0;
        model_tmp         = 8'h00;
        rst_n             = 1'b0;
        instruction       = 8'h00;
        run_phase         = 4'd0;
        psw               = 8'h00;
        ram_data_register = 8'h00;
        rom_data_register = 8'h00;
        repeat (4) next_fall();
        rst_n = 1'b1;

        test_reset_state();
        test_moves();
        test_alu();
        test_unary();
        test_direct_target();
        test_banks();

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+include
verilog/ins_decoder_pkg.sv
verilog/opcode_classifier.sv
verilog/phase_sequencer.sv
verilog/step_encoder.sv
verilog/ins_decoder_top.sv
testbench/tb_ins_decoder.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the decoder testbench with verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f flist.f --top-module tb_ins_decoder \
    -Mdir obj_dir -o tb_ins_decoder > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_ins_decoder > sim.log 2>&1
cat sim.log
grep -q '^RESULT: PASS$' sim.log && exit 0 || exit 1
